// File: Bender.yml
package:
  name: core_sys

sources:
  - common/core_pkg.sv
  - verilog/register_file.sv
  - verilog/system_decoder.sv
  - csr/csr_file.sv
  - verilog/core_control.sv
  - verilog/core_top.sv
  - target: test
    files:
      - test/fetch_memory.sv
      - test/tb_core.sv

// File: common/core_pkg.sv
package core_pkg;

   ////////////////////
   // widths and types
   ////////////////////

   localparam int xlen = 32;
   localparam int reg_addr_w = 5;
   localparam int csr_addr_w = 12;

   typedef logic [xlen-1:0] word_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;
   typedef logic [csr_addr_w-1:0] csr_addr_t;

   // decoded system operations
   typedef enum logic [3:0] {
      op_csrrw,
      op_csrrs,
      op_csrrc,
      op_csrrwi,
      op_csrrsi,
      op_csrrci,
      op_ecall,
      op_ebreak,
      op_mret,
      op_illegal
   } sys_op_t;

   ////////////////////
   // fetch and decode
   ////////////////////

   localparam word_t reset_vector = 32'h0000_1000;
   localparam word_t instr_len = 32'd4;
   localparam logic [6:0] opcode_system = 7'b1110011;

   // funct3 of the SYSTEM group
   localparam logic [2:0] funct3_priv = 3'b000;
   localparam logic [2:0] funct3_csrrw = 3'b001;
   localparam logic [2:0] funct3_csrrs = 3'b010;
   localparam logic [2:0] funct3_csrrc = 3'b011;
   localparam logic [2:0] funct3_csrrwi = 3'b101;
   localparam logic [2:0] funct3_csrrsi = 3'b110;
   localparam logic [2:0] funct3_csrrci = 3'b111;

   // fixed encodings of the privileged forms
   localparam word_t instr_ecall = 32'h0000_0073;
   localparam word_t instr_ebreak = 32'h0010_0073;
   localparam word_t instr_mret = 32'h3020_0073;

   ////////////////////
   // machine CSRs
   ////////////////////

   localparam csr_addr_t csr_mstatus = 12'h300;
   localparam csr_addr_t csr_misa = 12'h301;
   localparam csr_addr_t csr_mtvec = 12'h305;
   localparam csr_addr_t csr_mscratch = 12'h340;
   localparam csr_addr_t csr_mepc = 12'h341;
   localparam csr_addr_t csr_mcause = 12'h342;
   localparam csr_addr_t csr_mtval = 12'h343;
   localparam csr_addr_t csr_mcycle = 12'hb00;

   localparam word_t cause_illegal = 32'd2;
   localparam word_t cause_ebreak = 32'd3;
   localparam word_t cause_ecall_m = 32'd11;

   // mxl = 1 (rv32), extension I only
   localparam word_t misa_value = 32'h4000_0100;

   localparam int mstatus_mie_bit = 3;
   localparam int mstatus_mpie_bit = 7;

endpackage

// File: csr/csr_file.sv
module csr_file (
   input  logic                clk,
   input  logic                rstn,
   input  logic                exec,
   input  core_pkg::sys_op_t   op,
   input  core_pkg::csr_addr_t csr_addr,
   input  core_pkg::reg_addr_t rs1,
   input  core_pkg::word_t     rs1_data,
   input  core_pkg::word_t     instr,
   input  core_pkg::word_t     pc,
   output core_pkg::word_t     csr_rdata,
   output logic                rd_we,
   output logic                redirect,
   output core_pkg::word_t     redirect_pc
);

   // mstatus keeps only the two interrupt enable bits
   logic            mie;
   logic            mpie;
   core_pkg::word_t mtvec;
   core_pkg::word_t mscratch;
   core_pkg::word_t mepc;
   core_pkg::word_t mcause;
   core_pkg::word_t mtval;
   core_pkg::word_t mcycle;

   logic            csr_op;
   logic            imm_form;
   logic            wr_req;
   logic            csr_known;
   logic            trap;
   logic            mret_go;
   logic            csr_wr;
   core_pkg::word_t src;
   core_pkg::word_t wdata;
   core_pkg::word_t trap_cause;
   core_pkg::word_t trap_tval;

   ////////////////////
   // operation class
   ////////////////////

   assign csr_op = op inside {core_pkg::op_csrrw, core_pkg::op_csrrs, core_pkg::op_csrrc,
                              core_pkg::op_csrrwi, core_pkg::op_csrrsi, core_pkg::op_csrrci};
   assign imm_form = op inside {core_pkg::op_csrrwi, core_pkg::op_csrrsi, core_pkg::op_csrrci};

   // set and clear forms with rs1 field zero are pure reads
   assign wr_req = (op == core_pkg::op_csrrw) || (op == core_pkg::op_csrrwi) || (rs1 != '0);

   // 5-bit immediate is zero-extended
   assign src = imm_form ? core_pkg::word_t'(rs1) : rs1_data;

   ////////////////////
   // read and modify
   ////////////////////

   always_comb begin
      csr_known = 1'b1;
      csr_rdata = '0;
      case (csr_addr)
         core_pkg::csr_mstatus: begin
            csr_rdata[core_pkg::mstatus_mie_bit]  = mie;
            csr_rdata[core_pkg::mstatus_mpie_bit] = mpie;
         end
         core_pkg::csr_misa:     csr_rdata = core_pkg::misa_value;
         core_pkg::csr_mtvec:    csr_rdata = mtvec;
         core_pkg::csr_mscratch: csr_rdata = mscratch;
         core_pkg::csr_mepc:     csr_rdata = mepc;
         core_pkg::csr_mcause:   csr_rdata = mcause;
         core_pkg::csr_mtval:    csr_rdata = mtval;
         core_pkg::csr_mcycle:   csr_rdata = mcycle;
         default:                csr_known = 1'b0;
      endcase
   end

   always_comb begin
      case (op)
         core_pkg::op_csrrw, core_pkg::op_csrrwi: wdata = src;
         core_pkg::op_csrrs, core_pkg::op_csrrsi: wdata = csr_rdata | src;
         default:                                 wdata = csr_rdata & ~src;
      endcase
   end

   ////////////////////
   // trap and return
   ////////////////////

   assign trap = exec && ((op == core_pkg::op_illegal) || (op == core_pkg::op_ecall) ||
                          (op == core_pkg::op_ebreak) || (csr_op && !csr_known));
   assign mret_go = exec && (op == core_pkg::op_mret);
   assign csr_wr  = exec && csr_op && csr_known && wr_req;

   assign trap_cause = (op == core_pkg::op_ecall)  ? core_pkg::cause_ecall_m :
                       (op == core_pkg::op_ebreak) ? core_pkg::cause_ebreak :
                                                     core_pkg::cause_illegal;
   // only illegal instructions report the faulting word
   assign trap_tval = (op == core_pkg::op_ecall || op == core_pkg::op_ebreak) ? '0 : instr;

   // rd field taken straight from the word
   assign rd_we       = exec && csr_op && csr_known && (instr[11:7] != '0);
   assign redirect    = trap || mret_go;
   assign redirect_pc = trap ? {mtvec[31:2], 2'b00} : mepc;

   always_ff @(posedge clk) begin
      if (rstn) begin
         mie    <= 1'b0;
         mpie   <= 1'b0;
         mtvec  <= '0;
         mepc   <= '0;
         mcause <= '0;
         mcycle <= '0;
      end else begin
         mcycle <= mcycle + 1'b1;
         if (trap) begin
            mepc   <= pc;
            mcause <= trap_cause;
            mpie   <= mie;
            mie    <= 1'b0;
         end else if (mret_go) begin
            mie  <= mpie;
            mpie <= 1'b1;
         end else if (csr_wr) begin
            // misa and mcycle ignore writes
            case (csr_addr)
               core_pkg::csr_mstatus: begin
                  mie  <= wdata[core_pkg::mstatus_mie_bit];
                  mpie <= wdata[core_pkg::mstatus_mpie_bit];
               end
               core_pkg::csr_mtvec: begin
                  // modes 2 and 3 are reserved
                  if (wdata[1:0] < 2'd2) begin
                     mtvec <= wdata;
                  end
               end
               core_pkg::csr_mepc:   mepc   <= {wdata[31:2], 2'b00};
               core_pkg::csr_mcause: mcause <= wdata;
               default: begin
               end
            endcase
         end
      end
   end

   // data-only registers
   always_ff @(posedge clk) begin
      if (trap) begin
         mtval <= trap_tval;
      end else if (csr_wr && csr_addr == core_pkg::csr_mtval) begin
         mtval <= wdata;
      end
      if (csr_wr && csr_addr == core_pkg::csr_mscratch) begin
         mscratch <= wdata;
      end
   end

endmodule

// File: tb.f
common/core_pkg.sv
verilog/register_file.sv
verilog/system_decoder.sv
csr/csr_file.sv
verilog/core_control.sv
verilog/core_top.sv
test/fetch_memory.sv
test/tb_core.sv

// File: test/fetch_memory.sv
module fetch_memory (
   input  logic            clk,
   input  logic            rstn,
   input  logic            fetch_req,
   input  core_pkg::word_t fetch_addr,
   output logic            fetch_ack,
   output core_pkg::word_t fetch_data
);

   // low words hold trap targets, prog words the code at the reset vector
   core_pkg::word_t low_words [64];
   core_pkg::word_t prog_words [64];

   logic            busy;
   int unsigned     delay;
   int unsigned     delay_left;
   core_pkg::word_t req_addr;

   // unloaded words differ at every address
   function automatic core_pkg::word_t fill_word(input core_pkg::word_t addr);
      return {addr[15:0], addr[31:16]} ^ 32'hdead_beef;
   endfunction

   function automatic core_pkg::word_t read_word(input core_pkg::word_t addr);
      core_pkg::word_t offset;
      offset = addr - core_pkg::reset_vector;
      if (addr < 32'd256) begin
         return low_words[addr[7:2]];
      end else if (offset < 32'd256) begin
         return prog_words[offset[7:2]];
      end
      return fill_word(addr);
   endfunction

   task automatic write_word(input core_pkg::word_t addr, input core_pkg::word_t data);
      core_pkg::word_t offset;
      offset = addr - core_pkg::reset_vector;
      if (addr < 32'd256) begin
         low_words[addr[7:2]] = data;
      end else if (offset < 32'd256) begin
         prog_words[offset[7:2]] = data;
      end else begin
         $display("program word at %h lies outside the memory model", addr);
      end
   endtask

   initial begin
      void'($urandom(37));
      fetch_ack  = 1'b0;
      fetch_data = '0;
      busy       = 1'b0;
      delay_left = 0;
      req_addr   = '0;
      for (int i = 0; i < 64; i++) begin
         low_words[i]  = fill_word(i * 4);
         prog_words[i] = fill_word(core_pkg::reset_vector + i * 4);
      end
   end

   ////////////////////
   // fetch responder
   ////////////////////

   always @(posedge clk) begin
      fetch_ack <= 1'b0;
      if (rstn) begin
         busy <= 1'b0;
      end else if (busy) begin
         if (delay_left == 0) begin
            fetch_ack  <= 1'b1;
            fetch_data <= read_word(req_addr);
            busy       <= 1'b0;
         end else begin
            delay_left <= delay_left - 1;
         end
      end else if (fetch_req) begin
         // 0 to 5 idle cycles before the ack
         delay = $urandom % 6;
         if (delay == 0) begin
            fetch_ack  <= 1'b1;
            fetch_data <= read_word(fetch_addr);
         end else begin
            busy       <= 1'b1;
            delay_left <= delay - 1;
            req_addr   <= fetch_addr;
         end
      end
   end

endmodule

// File: test/tb_core.sv
module tb_core;

   logic                clk;
   logic                rstn;
   logic                fetch_req;
   core_pkg::word_t     fetch_addr;
   logic                fetch_ack;
   core_pkg::word_t     fetch_data;

   core_pkg::word_t     expected_addrs [$];
   string               expected_names [$];
   int                  checked = 0;
   int                  errors = 0;
   int                  cycles = 0;
   int                  cycle_limit = 0;
   logic                outstanding = 1'b0;

   // first handler reads mcause, second one jumps through mtval
   core_pkg::word_t     trap_entry = 32'd16;
   core_pkg::word_t     mtval_entry = 32'd28;
   core_pkg::csr_addr_t unlisted_csr = 12'h000;
   core_pkg::word_t     unknown_word;
   core_pkg::word_t     misa_block;

   core_top dut_i (
      .clk        (clk),
      .rstn       (rstn),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_ack  (fetch_ack),
      .fetch_data (fetch_data)
   );

   fetch_memory mem_i (
      .clk        (clk),
      .rstn       (rstn),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .fetch_ack  (fetch_ack),
      .fetch_data (fetch_data)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // I-type SYSTEM word: csr, rs1 or uimm, funct3, rd, opcode
   function automatic core_pkg::word_t csr_word(input logic [2:0] funct3,
         input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t src,
         input core_pkg::csr_addr_t csr);
      return {csr, src, funct3, rd, core_pkg::opcode_system};
   endfunction

   function automatic core_pkg::word_t word_aligned(input core_pkg::word_t value);
      return value & ~32'h3;
   endfunction

   // consecutive fetches from start
   task automatic expect_block(input core_pkg::word_t start, input int count, input string name);
      for (int i = 0; i < count; i++) begin
         expected_addrs.push_back(start + i * 4);
         expected_names.push_back(name);
      end
   endtask

   task automatic build_expected();
      expect_block(core_pkg::reset_vector, 1, "reset vector");
      expect_block(core_pkg::reset_vector + core_pkg::instr_len, 1, "after mtvec write");
      expect_block(trap_entry, 3, "ecall trap");
      expect_block(word_aligned(core_pkg::cause_ecall_m), 1, "mret to mepc from mcause");
      expect_block(trap_entry, 3, "all-zero word trap");
      expect_block(word_aligned(core_pkg::cause_illegal), 2, "mret after illegal trap");
      expect_block(mtval_entry, 3, "unknown csr trap");
      expect_block(word_aligned(unknown_word), 6, "mret to mtval");
      // csrrwi 31 then csrrci 3
      expect_block(word_aligned(32'd31 & ~32'd3), 3, "mret to mscratch");
      expect_block(misa_block, 4, "mret to cleared mtval");
      expect_block(word_aligned(core_pkg::misa_value), 1, "misa read through mepc");
   endtask

   task automatic load_program();
      core_pkg::word_t b4;
      b4 = word_aligned(unknown_word);
      mem_i.write_word(core_pkg::reset_vector,
                       csr_word(core_pkg::funct3_csrrwi, 0, 16, core_pkg::csr_mtvec));
      mem_i.write_word(core_pkg::reset_vector + 4, core_pkg::instr_ecall);
      mem_i.write_word(32'h00, csr_word(core_pkg::funct3_csrrwi, 0, 28, core_pkg::csr_mtvec));
      mem_i.write_word(32'h04, unknown_word);
      mem_i.write_word(32'h08, 32'h0000_0000);
      mem_i.write_word(32'h10, csr_word(core_pkg::funct3_csrrs, 5, 0, core_pkg::csr_mcause));
      mem_i.write_word(32'h14, csr_word(core_pkg::funct3_csrrw, 0, 5, core_pkg::csr_mepc));
      mem_i.write_word(32'h18, core_pkg::instr_mret);
      mem_i.write_word(32'h1c, csr_word(core_pkg::funct3_csrrs, 7, 0, core_pkg::csr_mtval));
      mem_i.write_word(32'h20, csr_word(core_pkg::funct3_csrrw, 0, 7, core_pkg::csr_mepc));
      mem_i.write_word(32'h24, core_pkg::instr_mret);
      // set and clear forms, then point mtval at the misa block
      mem_i.write_word(b4, csr_word(core_pkg::funct3_csrrwi, 0, 31, core_pkg::csr_mscratch));
      mem_i.write_word(b4 + 4, csr_word(core_pkg::funct3_csrrci, 0, 3, core_pkg::csr_mscratch));
      mem_i.write_word(b4 + 8, csr_word(core_pkg::funct3_csrrs, 6, 0, core_pkg::csr_mscratch));
      mem_i.write_word(b4 + 12, csr_word(core_pkg::funct3_csrrw, 0, 6, core_pkg::csr_mepc));
      mem_i.write_word(b4 + 16, csr_word(core_pkg::funct3_csrrci, 0, 16, core_pkg::csr_mtval));
      mem_i.write_word(b4 + 20, core_pkg::instr_mret);
      // read-only misa
      mem_i.write_word(misa_block, csr_word(core_pkg::funct3_csrrw, 0, 7, core_pkg::csr_misa));
      mem_i.write_word(misa_block + 4, csr_word(core_pkg::funct3_csrrs, 8, 0, core_pkg::csr_misa));
      mem_i.write_word(misa_block + 8, csr_word(core_pkg::funct3_csrrw, 0, 8, core_pkg::csr_mepc));
      mem_i.write_word(misa_block + 12, core_pkg::instr_mret);
   endtask

   ////////////////////
   // fetch checks
   ////////////////////

   always @(posedge clk) begin
      assert (!(rstn && fetch_req === 1'b1)) else begin
         $display("fetch_req went high while reset was active");
         errors++;
      end
      if (!rstn && fetch_req) begin
         assert (!outstanding) else begin
            $display("second fetch_req at %h before the previous one was acknowledged",
                     fetch_addr);
            errors++;
         end
         if (checked < expected_addrs.size()) begin
            assert (fetch_addr == expected_addrs[checked]) else begin
               $display("FAILED %s: expected %h, actual %h", expected_names[checked],
                        expected_addrs[checked], fetch_addr);
               errors++;
            end
         end
         checked++;
      end
      if (rstn) begin
         outstanding <= 1'b0;
      end else if (fetch_req) begin
         outstanding <= 1'b1;
      end else if (fetch_ack) begin
         outstanding <= 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles with %0d of %0d fetches seen", cycles, checked,
                  expected_addrs.size());
         $display("errors: %0d, fetches checked: %0d", errors, checked);
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      rstn = 1'b1;
      unknown_word = csr_word(core_pkg::funct3_csrrw, 0, 0, unlisted_csr);
      misa_block = word_aligned(unknown_word & ~32'd16);
      build_expected();
      // worst-case ack delay of 5 plus req, ack and exec cycles
      cycle_limit = expected_addrs.size() * (5 + 3) + 50;
      @(posedge clk);
      load_program();
      repeat (9) @(posedge clk);
      rstn <= 1'b0;
      while (checked < expected_addrs.size()) begin
         @(posedge clk);
      end
      $display("errors: %0d, fetches checked: %0d", errors, checked);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verilog/core_control.sv
module core_control (
   input  logic            clk,
   input  logic            rstn,
   output logic            fetch_req,
   output core_pkg::word_t fetch_addr,
   input  logic            fetch_ack,
   input  core_pkg::word_t fetch_data,
   output core_pkg::word_t instr,
   output core_pkg::word_t pc,
   output logic            exec,
   input  logic            redirect,
   input  core_pkg::word_t redirect_pc
);

   typedef enum logic [1:0] {
      st_fetch_req,
      st_fetch_wait,
      st_exec
   } state_t;

   state_t          state;
   core_pkg::word_t next_pc;

   // request address is the current pc
   assign fetch_addr = pc;

   // trap target or mepc wins over the sequential step
   assign next_pc = redirect ? redirect_pc : pc + core_pkg::instr_len;

   ////////////////////
   // instruction FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state     <= st_fetch_req;
         fetch_req <= 1'b0;
         exec      <= 1'b0;
         pc        <= core_pkg::reset_vector;
      end else begin
         // both are single-cycle pulses
         fetch_req <= 1'b0;
         exec      <= 1'b0;
         case (state)
            st_fetch_req: begin
               fetch_req <= 1'b1;
               state     <= st_fetch_wait;
            end
            st_fetch_wait: begin
               // hold here until the response shows up
               if (fetch_ack) begin
                  exec  <= 1'b1;
                  state <= st_exec;
               end
            end
            st_exec: begin
               // csr_file has settled redirect during exec
               pc        <= next_pc;
               fetch_req <= 1'b1;
               state     <= st_fetch_wait;
            end
            default: begin
               state <= st_fetch_req;
            end
         endcase
      end
   end

   // latch the word only while a request is pending
   always_ff @(posedge clk) begin
      if (state == st_fetch_wait && fetch_ack) begin
         instr <= fetch_data;
      end
   end

endmodule

// File: verilog/core_top.sv
module core_top (
   input  logic            clk,
   input  logic            rstn,
   output logic            fetch_req,
   output core_pkg::word_t fetch_addr,
   input  logic            fetch_ack,
   input  core_pkg::word_t fetch_data
);

   core_pkg::word_t     instr;
   core_pkg::word_t     pc;
   logic                exec;
   logic                redirect;
   core_pkg::word_t     redirect_pc;

   core_pkg::sys_op_t   op;
   core_pkg::reg_addr_t rd;
   core_pkg::reg_addr_t rs1;
   core_pkg::csr_addr_t csr_addr;

   core_pkg::word_t     rs1_data;
   core_pkg::word_t     csr_rdata;
   logic                rd_we;

   // sequencing and pc
   core_control control_i (
      .clk         (clk),
      .rstn        (rstn),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .fetch_ack   (fetch_ack),
      .fetch_data  (fetch_data),
      .instr       (instr),
      .pc          (pc),
      .exec        (exec),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   system_decoder decoder_i (
      .instr    (instr),
      .op       (op),
      .rd       (rd),
      .rs1      (rs1),
      .csr_addr (csr_addr)
   );

   csr_file csr_i (
      .clk         (clk),
      .rstn        (rstn),
      .exec        (exec),
      .op          (op),
      .csr_addr    (csr_addr),
      .rs1         (rs1),
      .rs1_data    (rs1_data),
      .instr       (instr),
      .pc          (pc),
      .csr_rdata   (csr_rdata),
      .rd_we       (rd_we),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   // csr read value goes back to rd
   register_file regs_i (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (rs1),
      .rs1_data (rs1_data),
      .we       (rd_we),
      .rd       (rd),
      .rd_data  (csr_rdata)
   );

endmodule

// File: verilog/register_file.sv
module register_file (
   input  logic                clk,
   input  logic                rstn,
   input  core_pkg::reg_addr_t rs1,
   output core_pkg::word_t     rs1_data,
   input  logic                we,
   input  core_pkg::reg_addr_t rd,
   input  core_pkg::word_t     rd_data
);

   core_pkg::word_t regs [32];

   // x0 reads as zero whatever is stored there
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[rd] <= rd_data;
      end
   end

endmodule

// File: verilog/system_decoder.sv
module system_decoder (
   input  core_pkg::word_t     instr,
   output core_pkg::sys_op_t   op,
   output core_pkg::reg_addr_t rd,
   output core_pkg::reg_addr_t rs1,
   output core_pkg::csr_addr_t csr_addr
);

   logic [6:0] opcode;
   logic [2:0] funct3;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];

   // fixed field positions of the I-type layout
   assign rd       = instr[11:7];
   assign rs1      = instr[19:15];
   assign csr_addr = instr[31:20];

   ////////////////////
   // operation
   ////////////////////

   always_comb begin
      op = core_pkg::op_illegal;
      if (opcode == core_pkg::opcode_system) begin
         case (funct3)
            core_pkg::funct3_csrrw:  op = core_pkg::op_csrrw;
            core_pkg::funct3_csrrs:  op = core_pkg::op_csrrs;
            core_pkg::funct3_csrrc:  op = core_pkg::op_csrrc;
            core_pkg::funct3_csrrwi: op = core_pkg::op_csrrwi;
            core_pkg::funct3_csrrsi: op = core_pkg::op_csrrsi;
            core_pkg::funct3_csrrci: op = core_pkg::op_csrrci;
            core_pkg::funct3_priv: begin
               // whole word must match, other fields are reserved
               if (instr == core_pkg::instr_ecall) begin
                  op = core_pkg::op_ecall;
               end else if (instr == core_pkg::instr_ebreak) begin
                  op = core_pkg::op_ebreak;
               end else if (instr == core_pkg::instr_mret) begin
                  op = core_pkg::op_mret;
               end
            end
            default: begin
               op = core_pkg::op_illegal;
            end
         endcase
      end
   end

endmodule
